/* hw/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

`define CORE_NREGS 16   // Architectural registers

`define CORE_XLEN 32    // Data word width

`define CORE_PCW 22     // PC counts words

`define CORE_ADRW 24    // Byte address on the data bus

`define CORE_PMAW 9     // Program memory word address

// Word address fetched first after reset
`define CORE_START 0

`endif

/* hw/isaPkg.sv */
package isaPkg;

  typedef enum logic [3:0] {
    OP_MOV = 4'd0,
    OP_LSL = 4'd1,
    OP_ASR = 4'd2,
    OP_ROR = 4'd3,
    OP_AND = 4'd4,
    OP_ANN = 4'd5,
    OP_IOR = 4'd6,
    OP_XOR = 4'd7,
    OP_ADD = 4'd8,
    OP_SUB = 4'd9
  } aluOp_e;

  typedef enum logic [2:0] {
    CC_MI, CC_EQ, CC_CS, CC_VS, CC_LS, CC_LT, CC_LE, CC_T
  } condCode_e;

  typedef struct packed {
    logic p, q, u, v;
    logic [3:0] ira;
    logic [3:0] irb;
    aluOp_e op;
    logic [15:0] imm;     // Low nibble doubles as irc
  } regFmt_s;

  typedef struct packed {
    logic p, q, u, v;     // u selects store
    logic [3:0] ira;
    logic [3:0] irb;
    logic [19:0] off;
  } memFmt_s;

  typedef struct packed {
    logic p, q, u, v;     // u selects PC-relative
    logic inv;
    condCode_e cc;
    logic [1:0] pad;
    logic [21:0] disp;    // Low nibble doubles as irc
  } brFmt_s;

  typedef union packed {
    regFmt_s rFmt;
    memFmt_s mFmt;
    brFmt_s bFmt;
  } instrWord_u;

  typedef struct packed {
    logic isReg;
    logic isLdr;
    logic isStr;
    logic isBr;
    logic useImm;
    aluOp_e op;
    logic u;
    condCode_e cc;
    logic inv;
    logic we;             // Writes ra at some point
  } ctrl_s;

endpackage

/* hw/busPkg.sv */
`include "core_macros.svh"

package busPkg;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic ov;
  } flags_s;

  // Request side of the rd/wr/adr/memwait bus
  typedef struct packed {
    logic [`CORE_ADRW-1:0] adr;
    logic rd;
    logic wr;
    logic [`CORE_XLEN-1:0] wdata;
  } dataReq_s;

endpackage

/* hw/regFile.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module regFile (
  input  logic                  clk,
  input  logic [3:0]            raddrB,
  input  logic [3:0]            raddrC,
  input  logic [3:0]            raddrA,
  input  logic                  we,
  input  logic [3:0]            waddr,
  input  logic [`CORE_XLEN-1:0] wdata,
  output logic [`CORE_XLEN-1:0] rdataB,
  output logic [`CORE_XLEN-1:0] rdataC,
  output logic [`CORE_XLEN-1:0] rdataA
);

  logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

  always_ff @(posedge clk) begin
    if (we) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdataB = regs[raddrB];
  assign rdataC = regs[raddrC];
  assign rdataA = regs[raddrA];   // Store data

  waddrKnown: assert property (@(posedge clk) we |-> !$isunknown(waddr))
    else $error("regFile write with unknown address");

endmodule

/* hw/instrDecoder.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module instrDecoder (
  input  isaPkg::instrWord_u    instr,
  output isaPkg::ctrl_s         ctrl,
  output logic [3:0]            ira,
  output logic [3:0]            irb,
  output logic [3:0]            irc,
  output logic [`CORE_XLEN-1:0] immExt,
  output logic [19:0]           off,
  output logic [21:0]           disp
);

  import isaPkg::*;

  logic p;
  logic q;

  assign p = instr.rFmt.p;   // Same bits in every view
  assign q = instr.rFmt.q;

  always_comb begin
    ctrl.isReg  = ~p;
    ctrl.isLdr  = p & ~q & ~instr.mFmt.u;
    ctrl.isStr  = p & ~q & instr.mFmt.u;
    ctrl.isBr   = p & q;
    ctrl.useImm = ~p & q;
    // Memory and branch words run the ALU as MOV of C
    ctrl.op     = (~p && instr.rFmt.op <= OP_SUB) ? instr.rFmt.op : OP_MOV;
    ctrl.u      = instr.rFmt.u;
    ctrl.cc     = instr.bFmt.cc;
    ctrl.inv    = instr.bFmt.inv;
    ctrl.we     = ~p | (~q & ~instr.mFmt.u);
  end

  assign ira = instr.rFmt.ira;        // Same bits in mFmt
  assign irb = instr.rFmt.irb;
  assign irc = instr.rFmt.imm[3:0];   // Also the low nibble of disp

  assign immExt = {{(`CORE_XLEN-16){instr.rFmt.v}}, instr.rFmt.imm};
  assign off    = instr.mFmt.off;
  assign disp   = instr.bFmt.disp;

endmodule

/* hw/execUnit.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module execUnit (
  input  logic                  clk,
  input  logic                  rst,
  input  isaPkg::ctrl_s         ctrl,
  input  logic [`CORE_XLEN-1:0] opB,
  input  logic [`CORE_XLEN-1:0] opC,
  input  logic [`CORE_XLEN-1:0] immExt,
  input  logic [19:0]           off,
  input  logic                  freeze,
  output logic [`CORE_XLEN-1:0] result,
  output logic [`CORE_ADRW-1:0] memAdr,
  output busPkg::flags_s        flags
);

  import isaPkg::*;

  logic [`CORE_XLEN-1:0]   c1;
  logic [4:0]              shAmt;
  logic [2*`CORE_XLEN-1:0] rotWide;
  logic [`CORE_XLEN:0]     sumWide;
  logic [`CORE_XLEN:0]     diffWide;
  logic                    isAdd;
  logic                    isSub;
  logic                    sa;
  logic                    sb;
  logic                    sc;
  logic                    ovNext;

  assign c1       = ctrl.useImm ? immExt : opC;
  assign shAmt    = c1[4:0];
  assign rotWide  = {opB, opB} >> shAmt;
  assign sumWide  = {1'b0, opB} + {1'b0, c1};
  assign diffWide = {1'b0, opB} - {1'b0, c1};   // Top bit is the borrow

  assign isAdd = ctrl.isReg & (ctrl.op == OP_ADD);
  assign isSub = ctrl.isReg & (ctrl.op == OP_SUB);

  always_comb begin
    case (ctrl.op)
      OP_LSL:  result = opB << shAmt;
      OP_ASR:  result = $signed(opB) >>> shAmt;
      OP_ROR:  result = rotWide[`CORE_XLEN-1:0];
      OP_AND:  result = opB & c1;
      OP_ANN:  result = opB & ~c1;
      OP_IOR:  result = opB | c1;
      OP_XOR:  result = opB ^ c1;
      OP_ADD:  result = sumWide[`CORE_XLEN-1:0];
      OP_SUB:  result = diffWide[`CORE_XLEN-1:0];
      default: result = (ctrl.useImm & ctrl.u) ? {immExt[15:0], 16'b0} : c1;   // MOV
    endcase
  end

  assign sa = result[`CORE_XLEN-1];
  assign sb = opB[`CORE_XLEN-1];
  assign sc = c1[`CORE_XLEN-1];

  // Signed overflow from the operand and result signs
  assign ovNext = isAdd ? ((sa & ~sb & ~sc) | (~sa & sb & sc)) :
                          ((sa & ~sb & sc) | (~sa & sb & ~sc));

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (!freeze) begin
      if (ctrl.we) begin   // Loads included, result carries inbus
        flags.n <= sa;
        flags.z <= (result == '0);
      end
      if (isAdd | isSub) begin
        flags.c  <= isAdd ? sumWide[`CORE_XLEN] : diffWide[`CORE_XLEN];
        flags.ov <= ovNext;
      end
    end
  end

  assign memAdr = opB[`CORE_ADRW-1:0] + {{(`CORE_ADRW-20){off[19]}}, off};

endmodule

/* hw/branchUnit.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module branchUnit (
  input  logic                  clk,
  input  logic                  rst,
  input  isaPkg::ctrl_s         ctrl,
  input  busPkg::flags_s        flags,
  input  logic [21:0]           disp,
  input  logic [`CORE_XLEN-1:0] target,
  input  logic                  memwait,
  output logic [`CORE_PCW-1:0]  fetchAdr,
  output logic                  memPhase,
  output logic                  stall
);

  import isaPkg::*;

  logic [`CORE_PCW-1:0] pc;
  logic [`CORE_PCW-1:0] nxpc;
  logic [`CORE_PCW-1:0] pcNext;
  logic                 isMem;
  logic                 hold;
  logic                 sLt;
  logic                 condRaw;
  logic                 taken;

  assign isMem = ctrl.isLdr | ctrl.isStr;
  assign stall = isMem & ~memPhase;   // Request cycle
  assign hold  = stall & memwait;
  assign sLt   = flags.n ^ flags.ov;

  always_comb begin
    case (ctrl.cc)
      CC_MI:   condRaw = flags.n;
      CC_EQ:   condRaw = flags.z;
      CC_CS:   condRaw = flags.c;
      CC_VS:   condRaw = flags.ov;
      CC_LS:   condRaw = flags.c | flags.z;
      CC_LT:   condRaw = sLt;
      CC_LE:   condRaw = sLt | flags.z;
      default: condRaw = 1'b1;
    endcase
  end

  assign taken = ctrl.isBr & (ctrl.inv ^ condRaw);   // Bit 27 inverts
  assign nxpc  = pc + 1'b1;

  always_comb begin
    if (rst) begin
      pcNext = `CORE_PCW'(`CORE_START);   // First word ready when rst falls
    end else if (stall) begin
      pcNext = pc;
    end else if (taken && ctrl.u) begin
      pcNext = nxpc + disp;
    end else if (taken) begin
      pcNext = target[`CORE_PCW+1:2];
    end else begin
      pcNext = nxpc;
    end
  end

  assign fetchAdr = pcNext;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc       <= `CORE_PCW'(`CORE_START);
      memPhase <= 1'b0;
    end else if (!hold) begin
      pc       <= pcNext;
      memPhase <= stall;
    end
  end

  phaseOnMem: assert property (@(posedge clk) disable iff (rst) memPhase |-> isMem)
    else $error("memPhase set on a non-memory instruction");

endmodule

/* hw/programMemory.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module programMemory (
  input  logic                  clk,
  input  logic                  we,
  input  logic [`CORE_PMAW-1:0] wadr,
  input  logic [`CORE_XLEN-1:0] wdata,
  input  logic [`CORE_PMAW-1:0] radr,
  output isaPkg::instrWord_u    rdata
);

  logic [`CORE_XLEN-1:0] mem [2**`CORE_PMAW];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wadr] <= wdata;   // Load port
    end
    rdata <= mem[radr];     // Old data on a same-address write
  end

endmodule

/* hw/risc5Core.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module risc5Core (
  input  logic                  clk,
  input  logic                  rst,
  input  isaPkg::instrWord_u    instr,
  output logic [`CORE_PCW-1:0]  fetchAdr,
  input  logic [`CORE_XLEN-1:0] inbus,
  input  logic                  memwait,
  output busPkg::dataReq_s      dataReq
);

  import isaPkg::*;
  import busPkg::*;

  ctrl_s                 ctrl;
  flags_s                flags;
  logic [3:0]            ira;
  logic [3:0]            irb;
  logic [3:0]            irc;
  logic [`CORE_XLEN-1:0] immExt;
  logic [19:0]           off;
  logic [21:0]           disp;
  logic [`CORE_XLEN-1:0] rdataA;
  logic [`CORE_XLEN-1:0] rdataB;
  logic [`CORE_XLEN-1:0] rdataC;
  logic [`CORE_XLEN-1:0] opC;
  logic [`CORE_XLEN-1:0] result;
  logic [`CORE_ADRW-1:0] memAdr;
  logic                  memPhase;
  logic                  stall;
  logic                  regWe;

  // Write-back choice: loads pass inbus through C, so N and Z see it
  assign opC   = ctrl.isLdr ? inbus : rdataC;
  assign regWe = ctrl.isReg | (ctrl.isLdr & memPhase);

  instrDecoder instrDecoder_inst (
    .instr  (instr),
    .ctrl   (ctrl),
    .ira    (ira),
    .irb    (irb),
    .irc    (irc),
    .immExt (immExt),
    .off    (off),
    .disp   (disp)
  );

  regFile regFile_inst (
    .clk    (clk),
    .raddrB (irb),
    .raddrC (irc),
    .raddrA (ira),
    .we     (regWe),
    .waddr  (ira),
    .wdata  (result),
    .rdataB (rdataB),
    .rdataC (rdataC),
    .rdataA (rdataA)
  );

  execUnit execUnit_inst (
    .clk    (clk),
    .rst    (rst),
    .ctrl   (ctrl),
    .opB    (rdataB),
    .opC    (opC),
    .immExt (immExt),
    .off    (off),
    .freeze (stall),
    .result (result),
    .memAdr (memAdr),
    .flags  (flags)
  );

  branchUnit branchUnit_inst (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .flags    (flags),
    .disp     (disp),
    .target   (rdataC),
    .memwait  (memwait),
    .fetchAdr (fetchAdr),
    .memPhase (memPhase),
    .stall    (stall)
  );

  assign dataReq = '{
    adr:   memAdr,
    rd:    ctrl.isLdr & stall,
    wr:    ctrl.isStr & stall,
    wdata: rdataA
  };

  // Request must not move while the memory is busy
  reqHeld: assert property (@(posedge clk) disable iff (rst)
    (dataReq.rd || dataReq.wr) && memwait |=> $stable(dataReq))
    else $error("bus request changed under memwait");

endmodule

/* hw/risc5System.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module risc5System (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  progWe,   // Used while rst is high
  input  logic [`CORE_PMAW-1:0] progAdr,
  input  logic [`CORE_XLEN-1:0] progData,
  output busPkg::dataReq_s      dataReq,
  input  logic [`CORE_XLEN-1:0] inbus,
  input  logic                  memwait
);

  import isaPkg::*;

  instrWord_u           instr;
  logic [`CORE_PCW-1:0] fetchAdr;

  risc5Core risc5Core_inst (
    .clk      (clk),
    .rst      (rst),
    .instr    (instr),
    .fetchAdr (fetchAdr),
    .inbus    (inbus),
    .memwait  (memwait),
    .dataReq  (dataReq)
  );

  programMemory programMemory_inst (
    .clk   (clk),
    .we    (progWe),
    .wadr  (progAdr),
    .wdata (progData),
    .radr  (fetchAdr[`CORE_PMAW-1:0]),   // Upper PC bits wrap
    .rdata (instr)
  );

endmodule

/* sim/risc5Tb.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module risc5Tb;

  import isaPkg::*;
  import busPkg::*;

  localparam int CYCLE_BUDGET = 3000;   // Program loads, resets and runs of all tests
  localparam logic [`CORE_ADRW-1:0] MARKER_ADR = 24'h3FC;

  logic                  clk;
  logic                  rst;
  logic                  progWe;
  logic [`CORE_PMAW-1:0] progAdr;
  logic [`CORE_XLEN-1:0] progData;
  dataReq_s              dataReq;
  logic [`CORE_XLEN-1:0] inbus = '0;
  logic                  memwait = 1'b0;

  logic [31:0] dmem [256];
  logic [31:0] prog [$];
  logic [23:0] stAdr [$];
  logic [31:0] stData [$];
  logic [23:0] expAdr [$];
  logic [31:0] expData [$];
  dataReq_s    reqSnap;
  logic        busy = 1'b0;
  logic        markerSeen;
  int          waitLeft;
  int          errors;
  int          checks;

  risc5System risc5System_inst (
    .clk      (clk),
    .rst      (rst),
    .progWe   (progWe),
    .progAdr  (progAdr),
    .progData (progData),
    .dataReq  (dataReq),
    .inbus    (inbus),
    .memwait  (memwait)
  );

  always #10 clk = ~clk;

  initial begin
    #(CYCLE_BUDGET * 20 * 2);
    $display("Watchdog expired, the run exceeded its cycle budget");
    $display("Test FAILED");
    $finish;
  end

  task automatic expectEq(string name, logic [31:0] exp, logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // Data memory with 0 to 3 wait cycles per request
  always @(negedge clk) begin
    if (rst) begin
      busy = 1'b0;
      memwait = 1'b0;
    end else if (dataReq.rd || dataReq.wr) begin
      if (!busy) begin
        busy = 1'b1;
        reqSnap = dataReq;
        waitLeft = $urandom % 4;
      end else begin
        checks++;
        assert (dataReq === reqSnap) else begin   // Request must hold under memwait
          errors++;
          $display("ERR %0t dataReq expected %h got %h", $time, reqSnap, dataReq);
        end
        waitLeft--;
      end
      memwait = (waitLeft != 0);
      if (waitLeft == 0) begin   // Completes on the coming rising edge
        busy = 1'b0;
        if (dataReq.wr) begin
          dmem[dataReq.adr[9:2]] = dataReq.wdata;
          if (dataReq.adr == MARKER_ADR) begin
            markerSeen = 1'b1;
          end else begin
            stAdr.push_back(dataReq.adr);
            stData.push_back(dataReq.wdata);
          end
        end else begin
          inbus = dmem[dataReq.adr[9:2]];   // Held through the load's second cycle
        end
      end
    end else begin
      memwait = 1'b0;
    end
  end

  function automatic logic [31:0] encReg(logic [3:0] op, int a, int b, int c);
    return {4'b0000, 4'(a), 4'(b), op, 12'b0, 4'(c)};
  endfunction

  function automatic logic [31:0] encImm(logic [3:0] op, int a, int b, int imm,
                                         logic u, logic v);
    return {2'b01, u, v, 4'(a), 4'(b), op, 16'(imm)};
  endfunction

  function automatic logic [31:0] encMem(logic store, int a, int b, int off);
    return {2'b10, store, 1'b0, 4'(a), 4'(b), 20'(off)};
  endfunction

  function automatic logic [31:0] encBr(logic rel, logic inv, logic [2:0] cc, int disp);
    return {2'b11, rel, 1'b0, inv, cc, 2'b00, 22'(disp)};
  endfunction

  function automatic logic [31:0] rotRight(logic [31:0] val, logic [4:0] sh);
    return (val >> sh) | (val << (32 - sh));
  endfunction

  function automatic logic condHolds(logic [2:0] cc, logic n, logic z, logic c, logic v);
    case (cc)
      3'd0:    return n;
      3'd1:    return z;
      3'd2:    return c;
      3'd3:    return v;
      3'd4:    return c | z;
      3'd5:    return n ^ v;
      3'd6:    return (n ^ v) | z;
      default: return 1'b1;
    endcase
  endfunction

  task automatic emit(logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic emitConst(int r, logic [31:0] val);
    emit(encImm(OP_MOV, r, 0, val[31:16], 1'b1, 1'b0));   // High half first
    emit(encImm(OP_IOR, r, r, val[15:0], 1'b0, 1'b0));
  endtask

  task automatic emitStore(int r, int adr);
    emit(encMem(1'b1, r, 0, adr));   // R0 holds zero
  endtask

  task automatic expectStore(int adr, logic [31:0] data);
    expAdr.push_back(24'(adr));
    expData.push_back(data);
  endtask

  task automatic startProgram;
    prog.delete();
    expAdr.delete();
    expData.delete();
    emit(encImm(OP_MOV, 0, 0, 0, 1'b0, 1'b0));
  endtask

  task automatic finishProgram;
    emitStore(0, MARKER_ADR);
    emit(encBr(1'b1, 1'b0, CC_T, -1));   // Spin in place
  endtask

  task automatic holdReset;
    rst = 1'b1;
    repeat (10) @(negedge clk);
    stAdr.delete();
    stData.delete();
    markerSeen = 1'b0;
    rst = 1'b0;
  endtask

  task automatic runProgram;
    rst = 1'b1;
    foreach (prog[i]) begin
      progWe = 1'b1;
      progAdr = `CORE_PMAW'(i);
      progData = prog[i];
      @(negedge clk);
    end
    progWe = 1'b0;
    holdReset();
    while (!markerSeen) @(negedge clk);
  endtask

  task automatic compareLog;
    expectEq("store count", expAdr.size(), stAdr.size());
    foreach (expAdr[i]) begin
      if (i < stAdr.size()) begin
        expectEq("dataReq.adr", expAdr[i], stAdr[i]);
        expectEq("dataReq.wdata", expData[i], stData[i]);
      end
    end
  endtask

  task automatic testArith;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] c;
    logic [15:0] d;
    logic [31:0] expv [9];
    a = 16'($urandom);
    b = 16'($urandom);
    c = 16'($urandom);
    d = 16'($urandom);
    expv[1] = {16'h0, a};
    expv[2] = {b, c};
    expv[3] = expv[1] + expv[2];
    expv[4] = expv[2] - expv[1];
    expv[5] = expv[1] + {16'hFFFF, d};   // v fills the upper half
    expv[6] = expv[2] - {16'h0, d};
    expv[7] = expv[3];
    expv[8] = {16'hFFFF, d};
    startProgram();
    emit(encImm(OP_MOV, 1, 0, a, 1'b0, 1'b0));
    emit(encImm(OP_MOV, 2, 0, b, 1'b1, 1'b0));
    emit(encImm(OP_IOR, 2, 2, c, 1'b0, 1'b0));
    emit(encReg(OP_ADD, 3, 1, 2));
    emit(encReg(OP_SUB, 4, 2, 1));
    emit(encImm(OP_ADD, 5, 1, d, 1'b0, 1'b1));
    emit(encImm(OP_SUB, 6, 2, d, 1'b0, 1'b0));
    emit(encReg(OP_MOV, 7, 0, 3));
    emit(encImm(OP_MOV, 8, 0, d, 1'b0, 1'b1));
    for (int r = 1; r <= 8; r++) begin
      emitStore(r, r * 4);
      expectStore(r * 4, expv[r]);
    end
    finishProgram();
    runProgram();
    compareLog();
  endtask

  task automatic testLogic;
    logic [31:0] x;
    logic [31:0] y;
    logic [4:0]  s1;
    logic [4:0]  s2;
    logic [4:0]  s3;
    logic [31:0] expv [11];
    x = $urandom | 32'h8000_0000;   // Negative so ASR fills with ones
    y = $urandom;
    s1 = 5'($urandom);
    s2 = 5'($urandom);
    s3 = 5'($urandom);
    expv[3] = x & y;
    expv[4] = x & ~y;
    expv[5] = x | y;
    expv[6] = x ^ y;
    expv[7] = x << s1;
    expv[8] = ~(~x >> s2);   // Ones shifted in from the top
    expv[9] = rotRight(x, s3);
    expv[10] = rotRight(y, s1);
    startProgram();
    emitConst(1, x);
    emitConst(2, y);
    emit(encReg(OP_AND, 3, 1, 2));
    emit(encReg(OP_ANN, 4, 1, 2));
    emit(encReg(OP_IOR, 5, 1, 2));
    emit(encReg(OP_XOR, 6, 1, 2));
    emit(encImm(OP_LSL, 7, 1, s1, 1'b0, 1'b0));
    emit(encImm(OP_ASR, 8, 1, s2, 1'b0, 1'b0));
    emit(encImm(OP_ROR, 9, 1, s3, 1'b0, 1'b0));
    emit(encImm(OP_MOV, 11, 0, s1, 1'b0, 1'b0));
    emit(encReg(OP_ROR, 10, 2, 11));   // Shift amount from a register
    for (int r = 3; r <= 10; r++) begin
      emitStore(r, 32'h40 + r * 4);
      expectStore(32'h40 + r * 4, expv[r]);
    end
    finishProgram();
    runProgram();
    compareLog();
  endtask

  task automatic testFlags;
    logic [31:0] xs [4];
    logic [31:0] ys [4];
    logic [32:0] diff;
    logic        n;
    logic        z;
    logic        c;
    logic        v;
    logic [3:0]  sel;
    xs[0] = 32'd5;
    ys[0] = 32'd5;
    xs[1] = 32'd1;
    ys[1] = 32'd2;
    xs[2] = 32'h7FFF_FFFF;
    ys[2] = 32'hFFFF_FFFF;
    xs[3] = $urandom;
    ys[3] = $urandom;
    startProgram();
    for (int p = 0; p < 4; p++) begin
      diff = {1'b0, xs[p]} - {1'b0, ys[p]};
      n = diff[31];
      z = (diff[31:0] == 32'h0);
      c = diff[32];   // Borrow
      v = (xs[p][31] != ys[p][31]) && (diff[31] != xs[p][31]);
      emit(encImm(OP_MOV, 4, 0, p + 1, 1'b0, 1'b0));
      emitConst(1, xs[p]);
      emitConst(2, ys[p]);
      emit(encReg(OP_SUB, 3, 1, 2));
      for (int k = 0; k < 16; k++) begin
        sel = 4'(k);
        emit(encBr(1'b1, sel[3], sel[2:0], 1));   // Taken skips the store
        emitStore(4, p * 64 + k * 4);
        if (!(sel[3] ^ condHolds(sel[2:0], n, z, c, v))) begin
          expectStore(p * 64 + k * 4, p + 1);
        end
      end
    end
    finishProgram();
    runProgram();
    compareLog();
  endtask

  task automatic testLoadStore;
    logic [31:0] vals [4];
    logic [15:0] adds [4];
    startProgram();
    emitConst(1, 32'h100);   // Base
    for (int k = 0; k < 4; k++) begin
      vals[k] = $urandom;
      adds[k] = 16'($urandom);
      emitConst(2, vals[k]);
      emit(encMem(1'b1, 2, 1, k * 4));
      expectStore(32'h100 + k * 4, vals[k]);
    end
    for (int k = 0; k < 4; k++) begin
      emit(encMem(1'b0, 3, 1, k * 4));
      emit(encImm(OP_ADD, 3, 3, adds[k], 1'b0, 1'b0));
      emit(encMem(1'b1, 3, 1, 32'h40 + k * 4));
      expectStore(32'h140 + k * 4, vals[k] + {16'h0, adds[k]});
    end
    emitConst(5, 32'h180);
    emit(encMem(1'b1, 2, 5, -4));   // Negative offset
    expectStore(32'h17C, vals[3]);
    emit(encMem(1'b0, 6, 5, -4));
    emit(encMem(1'b1, 6, 1, 32'h60));
    expectStore(32'h160, vals[3]);
    finishProgram();
    runProgram();
    compareLog();
  endtask

  task automatic testBranchReset;
    startProgram();
    emit(encImm(OP_MOV, 1, 0, 32'h111, 1'b0, 1'b0));
    emitStore(1, 32'h10);
    expectStore(32'h10, 32'h111);
    emit(encImm(OP_MOV, 2, 0, 28, 1'b0, 1'b0));   // Byte address of word 7
    emit(encBr(1'b0, 1'b0, CC_T, 2));
    emit(encImm(OP_MOV, 1, 0, 32'h222, 1'b0, 1'b0));
    emitStore(1, 32'h14);
    emit(encImm(OP_MOV, 3, 0, 32'h333, 1'b0, 1'b0));
    emitStore(3, 32'h18);
    expectStore(32'h18, 32'h333);
    finishProgram();
    runProgram();
    compareLog();
    // Cut the next run short, then let it start over
    rst = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk);
    holdReset();
    while (!markerSeen) @(negedge clk);
    compareLog();
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    progWe = 1'b0;
    progAdr = '0;
    progData = '0;
    markerSeen = 1'b0;
    errors = 0;
    checks = 0;
    void'($urandom(14));
    foreach (dmem[i]) begin
      dmem[i] = {4{8'(i)}};
    end
    repeat (10) @(negedge clk);
    testArith();
    testLogic();
    testFlags();
    testLoadStore();
    testBranchReset();
    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+hw
hw/isaPkg.sv
hw/busPkg.sv
hw/regFile.sv
hw/instrDecoder.sv
hw/execUnit.sv
hw/branchUnit.sv
hw/programMemory.sv
hw/risc5Core.sv
hw/risc5System.sv
sim/risc5Tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module risc5Tb -o risc5Sim

./obj_dir/risc5Sim > sim.log 2>&1 || true
cat sim.log

grep -qx "Test OK" sim.log
